//--- ebi_pkg.sv
`default_nettype none

package ebi_pkg;

  localparam int DATA_W    = 16;
  localparam int ADDR_W    = 19;
  localparam int CMD_WORDS = 5;
  localparam int CMD_W     = 80;
  localparam int TIME_W    = 32;

  // ----------------------------------------------------------------------
  // register map
  // ----------------------------------------------------------------------
  localparam logic [ADDR_W-1:0] ADDR_STATUS      = 19'd0;
  localparam logic [ADDR_W-1:0] ADDR_CMD_W1      = 19'd1;
  localparam logic [ADDR_W-1:0] ADDR_CMD_W2      = 19'd2;
  localparam logic [ADDR_W-1:0] ADDR_CMD_W3      = 19'd3;
  localparam logic [ADDR_W-1:0] ADDR_CMD_W4      = 19'd4;
  // writing the last word commits the command
  localparam logic [ADDR_W-1:0] ADDR_CMD_W5      = 19'd5;
  localparam logic [ADDR_W-1:0] ADDR_NEXT_SAMPLE = 19'd6;
  localparam logic [ADDR_W-1:0] ADDR_TIME_RESET  = 19'd7;
  localparam logic [ADDR_W-1:0] ADDR_TIME_RUN    = 19'd8;
  localparam logic [ADDR_W-1:0] ADDR_TIME_READ   = 19'd9;

  localparam logic [DATA_W-1:0] SAMPLE_RESET_VALUE = 16'hDEAD;

  // order of the 4-bit flag vector out of each fifo
  localparam int FLAG_EMPTY  = 0;
  localparam int FLAG_AEMPTY = 1;
  localparam int FLAG_FULL   = 2;
  localparam int FLAG_AFULL  = 3;

  // status word layout, bits 7..0 read as zero
  localparam int ST_CMD_AFULL     = 15;
  localparam int ST_CMD_FULL      = 14;
  localparam int ST_CMD_AEMPTY    = 13;
  localparam int ST_CMD_EMPTY     = 12;
  localparam int ST_SAMPLE_AFULL  = 11;
  localparam int ST_SAMPLE_FULL   = 10;
  localparam int ST_SAMPLE_EMPTY  = 9;
  localparam int ST_SAMPLE_AEMPTY = 8;

endpackage

`default_nettype wire

//--- ebi_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ebi_bus_if;
  import ebi_pkg::*;

  // host bus, already synchronous to clk
  logic [DATA_W-1:0] data_in;
  logic [ADDR_W-1:0] addr;
  logic              cs;
  logic              rd;
  logic              wr;

  modport ctrl (
    input data_in,
    input addr,
    input cs,
    input rd,
    input wr
  );

  // word capture only needs the payload and where it goes
  modport capture (
    input data_in,
    input addr
  );

endinterface

`default_nettype wire

//--- ebi_control.sv
`timescale 1ns/1ps
`default_nettype none

module ebi_control (
  input  logic                      clk,
  input  logic                      rst,
  ebi_bus_if.ctrl                   bus,
  input  logic [ebi_pkg::DATA_W-1:0] status_word,
  input  logic [ebi_pkg::DATA_W-1:0] sample_latch,
  input  logic [ebi_pkg::DATA_W-1:0] time_low,
  output logic                      cmd_push,
  output logic                      capture_en,
  output logic                      sample_pop,
  output logic                      sample_load,
  output logic                      status_read,
  output logic                      time_reset,
  output logic                      time_run,
  output logic [ebi_pkg::DATA_W-1:0] data_out
);
  import ebi_pkg::*;

  // one-hot states
  localparam logic [5:0] idle           = 6'b000001;
  localparam logic [5:0] fetch          = 6'b000010;
  localparam logic [5:0] fifo_load      = 6'b000100;
  localparam logic [5:0] trans_over     = 6'b001000;
  localparam logic [5:0] fifo_read      = 6'b010000;
  localparam logic [5:0] fifo_read_next = 6'b100000;

  logic [5:0] state;
  logic [5:0] next_state;
  logic       wr_seen;
  logic       rd_seen;
  logic       rd_d;
  logic       rd_dd;
  logic       rd_done;

  assign wr_seen = bus.cs & bus.wr;
  assign rd_seen = bus.cs & bus.rd;

  // ----------------------------------------------------------------------
  // end of read strobe, two register stages
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_d  <= 1'b0;
      rd_dd <= 1'b0;
    end else begin
      rd_d  <= rd_seen;
      rd_dd <= rd_d;
    end
  end

  assign rd_done = rd_dd & ~rd_d;

  // ----------------------------------------------------------------------
  // state machine
  // ----------------------------------------------------------------------
  always_comb begin
    next_state = state;
    capture_en = 1'b0;
    time_reset = 1'b0;
    time_run   = 1'b0;
    case (state)
      idle: next_state = fetch;
      fetch: begin
        if (wr_seen) begin
          capture_en = 1'b1;
          if (bus.addr == ADDR_CMD_W5) next_state = fifo_load;
          else if (bus.addr == ADDR_TIME_RESET) time_reset = 1'b1;
          else if (bus.addr == ADDR_TIME_RUN) time_run = 1'b1;
        end else if (rd_seen && bus.addr == ADDR_NEXT_SAMPLE) begin
          next_state = fifo_read;
        end
      end
      fifo_load: next_state = trans_over;
      // host may still hold the strobe of the last word
      trans_over: if (!bus.rd && !bus.wr) next_state = fetch;
      fifo_read: if (rd_done) next_state = fifo_read_next;
      fifo_read_next: next_state = fetch;
      default: next_state = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= idle;
      cmd_push    <= 1'b0;
      sample_pop  <= 1'b0;
      sample_load <= 1'b0;
    end else begin
      state       <= next_state;
      cmd_push    <= (state == fifo_load);
      sample_pop  <= (state == fifo_read) && rd_done;
      // popped word is on the fifo output one cycle after the pop
      sample_load <= (state == fifo_read_next);
    end
  end

  // ----------------------------------------------------------------------
  // registered read mux
  // ----------------------------------------------------------------------
  assign status_read = rd_seen && (bus.addr == ADDR_STATUS);

  always_ff @(posedge clk) begin
    if (rst) begin
      data_out <= '0;
    end else if (rd_seen) begin
      case (bus.addr)
        ADDR_STATUS:      data_out <= status_word;
        ADDR_NEXT_SAMPLE: data_out <= sample_latch;
        ADDR_TIME_READ:   data_out <= time_low;
        default:          data_out <= data_out;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- cmd_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_assembler (
  input  logic                      clk,
  input  logic                      rst,
  ebi_bus_if.capture                bus,
  input  logic                      capture_en,
  output logic [ebi_pkg::CMD_W-1:0] command
);
  import ebi_pkg::*;

  localparam int IDX_W = $clog2(CMD_WORDS);

  logic [DATA_W-1:0] words [CMD_WORDS];
  logic [IDX_W-1:0]  idx;
  logic              in_range;

  // only command addresses land in the bank, timer writes fall through
  assign in_range = (bus.addr >= ADDR_CMD_W1) && (bus.addr <= ADDR_CMD_W5);
  assign idx      = IDX_W'(bus.addr - ADDR_CMD_W1);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < CMD_WORDS; i++) words[i] <= '0;
    end else if (capture_en && in_range) begin
      words[idx] <= bus.data_in;
    end
  end

  // word 1 ends up in the top bits
  always_comb begin
    for (int j = 0; j < CMD_WORDS; j++) begin
      command[CMD_W-1-j*DATA_W -: DATA_W] = words[j];
    end
  end

endmodule

`default_nettype wire

//--- sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int WIDTH         = 16,
  parameter int DEPTH         = 16,
  parameter int ALMOST_MARGIN = 2
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             wr_en,
  input  logic [WIDTH-1:0] wr_data,
  input  logic             rd_en,
  output logic [WIDTH-1:0] rd_data,
  output logic             full,
  output logic             empty,
  output logic             almost_full,
  output logic             almost_empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_wr;
  logic             do_rd;

  // blocked accesses are dropped
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  always_ff @(posedge clk) begin
    if (do_wr) mem[wr_ptr] <= wr_data;
    if (do_rd) rd_data <= mem[rd_ptr];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_wr && !do_rd) count <= count + 1'b1;
      else if (do_rd && !do_wr) count <= count - 1'b1;
    end
  end

  // flags straight from occupancy
  assign full         = (count == CNT_W'(DEPTH));
  assign empty        = (count == '0);
  assign almost_full  = (count >= CNT_W'(DEPTH - ALMOST_MARGIN));
  assign almost_empty = (count <= CNT_W'(ALMOST_MARGIN));

endmodule

`default_nettype wire

//--- status_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module status_monitor (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [3:0]                 cmd_flags,
  input  logic [3:0]                 sample_flags,
  input  logic                       status_read,
  input  logic                       sample_load,
  input  logic [ebi_pkg::DATA_W-1:0] sample_rd_data,
  output logic [ebi_pkg::DATA_W-1:0] status_word,
  output logic [ebi_pkg::DATA_W-1:0] sample_latch,
  output logic                       irq
);
  import ebi_pkg::*;

  logic [DATA_W-1:0] status_next;
  logic [DATA_W-1:0] status_last;

  always_comb begin
    status_next                   = '0;
    status_next[ST_CMD_AFULL]     = cmd_flags[FLAG_AFULL];
    status_next[ST_CMD_FULL]      = cmd_flags[FLAG_FULL];
    status_next[ST_CMD_AEMPTY]    = cmd_flags[FLAG_AEMPTY];
    status_next[ST_CMD_EMPTY]     = cmd_flags[FLAG_EMPTY];
    status_next[ST_SAMPLE_AFULL]  = sample_flags[FLAG_AFULL];
    status_next[ST_SAMPLE_FULL]   = sample_flags[FLAG_FULL];
    status_next[ST_SAMPLE_EMPTY]  = sample_flags[FLAG_EMPTY];
    status_next[ST_SAMPLE_AEMPTY] = sample_flags[FLAG_AEMPTY];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      status_word  <= '0;
      status_last  <= '0;
      irq          <= 1'b0;
      sample_latch <= SAMPLE_RESET_VALUE;
    end else begin
      status_word <= status_next;
      if (status_read) status_last <= status_word;
      // stays up until the host has seen the current flags
      irq <= (status_word != status_last);
      // status_word holds the empty flag of the pop cycle here,
      // so an empty pop leaves the latch alone
      if (sample_load && !status_word[ST_SAMPLE_EMPTY]) sample_latch <= sample_rd_data;
    end
  end

endmodule

`default_nettype wire

//--- run_timer.sv
`timescale 1ns/1ps
`default_nettype none

module run_timer (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       time_reset,
  input  logic                       time_run,
  output logic [ebi_pkg::TIME_W-1:0] count
);

  logic run_en;

  always_ff @(posedge clk) begin
    if (rst) begin
      run_en <= 1'b0;
      count  <= '0;
    end else begin
      // sticky until reset
      if (time_run) run_en <= 1'b1;
      if (time_reset) count <= '0;
      else if (run_en) count <= count + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- ebi_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module ebi_bridge_top #(
  parameter int CMD_DEPTH     = 8,
  parameter int SAMPLE_DEPTH  = 16,
  parameter int ALMOST_MARGIN = 2
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [ebi_pkg::DATA_W-1:0] data_in,
  input  logic [ebi_pkg::ADDR_W-1:0] addr,
  input  logic                       cs,
  input  logic                       rd,
  input  logic                       wr,
  output logic [ebi_pkg::DATA_W-1:0] data_out,
  output logic                       irq,
  output logic [ebi_pkg::TIME_W-1:0] global_clock,
  input  logic                       cmd_rd_en,
  output logic [ebi_pkg::CMD_W-1:0]  cmd_data,
  output logic                       cmd_empty,
  input  logic                       sample_wr_en,
  input  logic [ebi_pkg::DATA_W-1:0] sample_data,
  output logic                       sample_full
);
  import ebi_pkg::*;

  logic              cmd_push;
  logic              capture_en;
  logic              sample_pop;
  logic              sample_load;
  logic              status_read;
  logic              time_reset;
  logic              time_run;
  logic [CMD_W-1:0]  command;
  logic [DATA_W-1:0] status_word;
  logic [DATA_W-1:0] sample_latch;
  logic [DATA_W-1:0] sample_rd_data;
  logic [TIME_W-1:0] time_count;
  logic [3:0]        cmd_flags;
  logic [3:0]        sample_flags;

  ebi_bus_if bus ();

  assign bus.data_in = data_in;
  assign bus.addr    = addr;
  assign bus.cs      = cs;
  assign bus.rd      = rd;
  assign bus.wr      = wr;

  ebi_control u_control (
    .clk(clk), .rst(rst), .bus(bus),
    .status_word(status_word), .sample_latch(sample_latch),
    .time_low(time_count[DATA_W-1:0]),
    .cmd_push(cmd_push), .capture_en(capture_en),
    .sample_pop(sample_pop), .sample_load(sample_load),
    .status_read(status_read),
    .time_reset(time_reset), .time_run(time_run),
    .data_out(data_out)
  );

  cmd_assembler u_assembler (
    .clk(clk), .rst(rst), .bus(bus), .capture_en(capture_en), .command(command)
  );

  // ----------------------------------------------------------------------
  // command and sample fifos
  // ----------------------------------------------------------------------
  sync_fifo #(.WIDTH(CMD_W), .DEPTH(CMD_DEPTH), .ALMOST_MARGIN(ALMOST_MARGIN)) cmd_fifo (
    .clk(clk), .rst(rst),
    .wr_en(cmd_push), .wr_data(command),
    .rd_en(cmd_rd_en), .rd_data(cmd_data),
    .full(cmd_flags[FLAG_FULL]), .empty(cmd_flags[FLAG_EMPTY]),
    .almost_full(cmd_flags[FLAG_AFULL]), .almost_empty(cmd_flags[FLAG_AEMPTY])
  );

  sync_fifo #(.WIDTH(DATA_W), .DEPTH(SAMPLE_DEPTH), .ALMOST_MARGIN(ALMOST_MARGIN)) sample_fifo (
    .clk(clk), .rst(rst),
    .wr_en(sample_wr_en), .wr_data(sample_data),
    .rd_en(sample_pop), .rd_data(sample_rd_data),
    .full(sample_flags[FLAG_FULL]), .empty(sample_flags[FLAG_EMPTY]),
    .almost_full(sample_flags[FLAG_AFULL]), .almost_empty(sample_flags[FLAG_AEMPTY])
  );

  assign cmd_empty   = cmd_flags[FLAG_EMPTY];
  assign sample_full = sample_flags[FLAG_FULL];

  status_monitor u_status (
    .clk(clk), .rst(rst),
    .cmd_flags(cmd_flags), .sample_flags(sample_flags),
    .status_read(status_read),
    .sample_load(sample_load), .sample_rd_data(sample_rd_data),
    .status_word(status_word), .sample_latch(sample_latch),
    .irq(irq)
  );

  run_timer u_timer (
    .clk(clk), .rst(rst), .time_reset(time_reset), .time_run(time_run), .count(time_count)
  );

  assign global_clock = time_count;

endmodule

`default_nettype wire

//--- ebi_chk.sv
`timescale 1ns/1ps
`default_nettype none

module ebi_chk #(
  parameter bit FIFO_SIDE = 1'b0
) (
  input logic       clk,
  input logic       rst,
  input logic [5:0] state,
  input logic       push,
  input logic       fifo_wr_en,
  input logic       fifo_rd_en,
  input logic       fifo_full
);

  if (!FIFO_SIDE) begin : g_ctrl
    // ----------------------------------------------------------------------
    // controller
    // ----------------------------------------------------------------------
    assert property (@(posedge clk) disable iff (rst) push |=> !push)
      else $error("cmd_push high for more than one cycle");

    assert property (@(posedge clk) disable iff (rst) $onehot(state))
      else $error("controller state is not one-hot");
  end else begin : g_fifo
    // fifo must stay full when a write meets a full buffer
    assert property (@(posedge clk) disable iff (rst)
                     fifo_full && fifo_wr_en && !fifo_rd_en |=> fifo_full)
      else $error("FIFO accepted a write while full");
  end

endmodule

bind ebi_control ebi_chk #(.FIFO_SIDE(1'b0)) u_ctrl_chk (
  .clk(clk), .rst(rst), .state(state), .push(cmd_push),
  .fifo_wr_en(1'b0), .fifo_rd_en(1'b0), .fifo_full(1'b0)
);

bind sync_fifo ebi_chk #(.FIFO_SIDE(1'b1)) u_fifo_chk (
  .clk(clk), .rst(rst), .state(6'b000001), .push(1'b0),
  .fifo_wr_en(wr_en), .fifo_rd_en(rd_en), .fifo_full(full)
);

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD = 40
) (
  output logic clk
);

  initial clk = 1'b0;

  // free-running, half period per edge
  always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- tb_ebi.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ebi;
  import ebi_pkg::*;

  localparam int CMD_DEPTH     = 8;
  localparam int SAMPLE_DEPTH  = 16;
  localparam int ALMOST_MARGIN = 2;
  localparam int TIMEOUT       = 20;

  logic              clk;
  logic              rst;
  logic [DATA_W-1:0] data_in;
  logic [ADDR_W-1:0] addr;
  logic              cs;
  logic              rd;
  logic              wr;
  logic [DATA_W-1:0] data_out;
  logic              irq;
  logic [TIME_W-1:0] global_clock;
  logic              cmd_rd_en;
  logic [CMD_W-1:0]  cmd_data;
  logic              cmd_empty;
  logic              sample_wr_en;
  logic [DATA_W-1:0] sample_data;
  logic              sample_full;

  // reference model
  logic [CMD_W-1:0]  cmd_q [$];
  logic [DATA_W-1:0] sample_q [$];
  logic [DATA_W-1:0] latch_model;
  logic [DATA_W-1:0] last_status;
  logic [TIME_W-1:0] clock_snap;

  tb_clock #(.PERIOD(40)) u_clock (.clk(clk));

  ebi_bridge_top #(
    .CMD_DEPTH(CMD_DEPTH), .SAMPLE_DEPTH(SAMPLE_DEPTH), .ALMOST_MARGIN(ALMOST_MARGIN)
  ) UUT (
    .clk(clk), .rst(rst), .data_in(data_in), .addr(addr), .cs(cs), .rd(rd), .wr(wr),
    .data_out(data_out), .irq(irq), .global_clock(global_clock),
    .cmd_rd_en(cmd_rd_en), .cmd_data(cmd_data), .cmd_empty(cmd_empty),
    .sample_wr_en(sample_wr_en), .sample_data(sample_data), .sample_full(sample_full)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input logic [CMD_W-1:0] got, input logic [CMD_W-1:0] want,
                       input string what);
    if (got !== want) begin
      abort_run($sformatf("** Error at %0t ns: %s, got %0h, expected %0h",
                          $time, what, got, want));
    end
  endtask

  // status layout built from the model queue sizes
  function automatic logic [DATA_W-1:0] model_status();
    int nc;
    int ns;
    logic [DATA_W-1:0] s;
    nc = cmd_q.size();
    ns = sample_q.size();
    s = '0;
    s[ST_CMD_AFULL]     = (nc >= CMD_DEPTH - ALMOST_MARGIN);
    s[ST_CMD_FULL]      = (nc == CMD_DEPTH);
    s[ST_CMD_AEMPTY]    = (nc <= ALMOST_MARGIN);
    s[ST_CMD_EMPTY]     = (nc == 0);
    s[ST_SAMPLE_AFULL]  = (ns >= SAMPLE_DEPTH - ALMOST_MARGIN);
    s[ST_SAMPLE_FULL]   = (ns == SAMPLE_DEPTH);
    s[ST_SAMPLE_EMPTY]  = (ns == 0);
    s[ST_SAMPLE_AEMPTY] = (ns <= ALMOST_MARGIN);
    return s;
  endfunction

  // ----------------------------------------------------------------------
  // bus access
  // ----------------------------------------------------------------------
  task automatic bus_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
    addr    = a;
    data_in = d;
    cs      = 1'b1;
    wr      = 1'b1;
    repeat (3) @(negedge clk);
    cs = 1'b0;
    wr = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  // idle tail covers the delayed sample pop and latch load
  task automatic bus_read(input logic [ADDR_W-1:0] a, output logic [DATA_W-1:0] d);
    addr = a;
    cs   = 1'b1;
    rd   = 1'b1;
    @(negedge clk);
    clock_snap = global_clock;
    @(negedge clk);
    d  = data_out;
    cs = 1'b0;
    rd = 1'b0;
    repeat (6) @(negedge clk);
  endtask

  task automatic check_irq();
    logic want;
    int n;
    want = (model_status() != last_status);
    n = 0;
    while (irq !== want && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    check(irq, want, "irq after flag change");
  endtask

  task automatic read_status();
    logic [DATA_W-1:0] d;
    int n;
    bus_read(ADDR_STATUS, d);
    check(d[7:0], 8'h00, "status low byte");
    check(d, model_status(), "status word");
    last_status = d;
    n = 0;
    while (irq) begin
      if (n == TIMEOUT) abort_run("timeout: irq stayed high after a status read");
      @(negedge clk);
      n++;
    end
  endtask

  task automatic write_command();
    logic [DATA_W-1:0] w [CMD_WORDS];
    logic [CMD_W-1:0]  cmd;
    for (int i = 0; i < CMD_WORDS; i++) begin
      w[i] = DATA_W'($urandom);
      bus_write(ADDR_CMD_W1 + ADDR_W'(i), w[i]);
    end
    cmd = {w[0], w[1], w[2], w[3], w[4]};
    if (cmd_q.size() < CMD_DEPTH) cmd_q.push_back(cmd);
    check_irq();
  endtask

  task automatic wait_cmd_ready();
    int n;
    n = 0;
    while (cmd_empty) begin
      if (n == TIMEOUT) abort_run("timeout: command never reached the command FIFO");
      @(negedge clk);
      n++;
    end
  endtask

  task automatic drain_command();
    logic [CMD_W-1:0] want;
    check(cmd_empty, cmd_q.size() == 0, "cmd_empty before drain");
    cmd_rd_en = 1'b1;
    @(negedge clk);
    cmd_rd_en = 1'b0;
    want = cmd_q.pop_front();
    check(cmd_data, want, "drained command");
    check_irq();
  endtask

  task automatic push_sample();
    logic [DATA_W-1:0] d;
    d = DATA_W'($urandom);
    sample_data  = d;
    sample_wr_en = 1'b1;
    @(negedge clk);
    sample_wr_en = 1'b0;
    if (sample_q.size() < SAMPLE_DEPTH) sample_q.push_back(d);
    check(sample_full, sample_q.size() == SAMPLE_DEPTH, "sample_full");
    check_irq();
  endtask

  // returns the latch, then the fifo head moves into it
  task automatic read_sample();
    logic [DATA_W-1:0] d;
    bus_read(ADDR_NEXT_SAMPLE, d);
    check(d, latch_model, "sample read");
    if (sample_q.size() > 0) latch_model = sample_q.pop_front();
    check_irq();
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    logic [DATA_W-1:0] t0;
    logic [DATA_W-1:0] t1;
    logic [DATA_W-1:0] t2;
    logic [TIME_W-1:0] gc_before;
    int n;
    void'($urandom(32'h5909b070));
    rst          = 1'b1;
    data_in      = '0;
    addr         = '0;
    cs           = 1'b0;
    rd           = 1'b0;
    wr           = 1'b0;
    cmd_rd_en    = 1'b0;
    sample_wr_en = 1'b0;
    sample_data  = '0;
    latch_model  = 16'hDEAD;
    last_status  = '0;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check(data_out, 16'h0000, "data_out after reset");

    // timer, stopped then running
    gc_before = global_clock;
    bus_write(ADDR_TIME_RESET, 16'h0000);
    bus_read(ADDR_TIME_READ, t0);
    check(t0 < 16, 1'b1, "timer low word after clear");
    check(global_clock, gc_before, "timer idle before run");
    bus_write(ADDR_TIME_RUN, 16'h0001);
    n = 5 + int'($urandom % 40);
    repeat (n) @(negedge clk);
    bus_read(ADDR_TIME_READ, t1);
    check(t1, clock_snap[DATA_W-1:0], "first time read");
    bus_read(ADDR_TIME_READ, t2);
    check(t2, clock_snap[DATA_W-1:0], "second time read");
    check(t2 > t1, 1'b1, "timer advancing");
    bus_write(ADDR_TIME_RESET, 16'h0000);
    bus_read(ADDR_TIME_READ, t0);
    check(t0 < 16, 1'b1, "timer low word after clear while running");

    check_irq();
    read_status();

    // command assembly, one at a time
    repeat (6) begin
      write_command();
      wait_cmd_ready();
      drain_command();
      if ($urandom % 3 == 0) read_status();
    end
    check(cmd_empty, 1'b1, "cmd_empty after single drains");

    // sample chain, including an overfilled fifo and empty reads
    read_sample();
    n = SAMPLE_DEPTH + 1 + int'($urandom % 3);
    repeat (n) begin
      push_sample();
      if ($urandom % 3 == 0) read_status();
    end
    repeat (n + 2) begin
      read_sample();
      if ($urandom % 3 == 0) read_status();
    end

    // no back-pressure, extra commands are dropped
    repeat (CMD_DEPTH + 2) write_command();
    read_status();
    check(last_status[ST_CMD_FULL], 1'b1, "cmd full in status");
    while (cmd_q.size() > 0) drain_command();
    check(cmd_empty, 1'b1, "cmd_empty after full drain");
    read_status();

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
ebi_pkg.sv
ebi_bus_if.sv
ebi_control.sv
cmd_assembler.sv
sync_fifo.sv
status_monitor.sv
run_timer.sv
ebi_bridge_top.sv
ebi_chk.sv
tb_clock.sv
tb_ebi.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := tb_ebi
FILELIST  := tb.f
OBJ_DIR   := obj_dir
PASS_MSG  := Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
